//--- vlog.f
verilog/divSqrtPkg.sv
verilog/divSqrtPreproc.sv
verilog/divSqrtStage.sv
verilog/divSqrtIter.sv
verilog/divSqrtFsm.sv
verilog/divSqrtPostproc.sv
verilog/divSqrtUnit.sv
tests/divSqrtTb.sv

//--- Bender.yml
package:
  name: div_sqrt_unit

sources:
  - verilog/divSqrtPkg.sv
  - verilog/divSqrtPreproc.sv
  - verilog/divSqrtStage.sv
  - verilog/divSqrtIter.sv
  - verilog/divSqrtFsm.sv
  - verilog/divSqrtPostproc.sv
  - verilog/divSqrtUnit.sv
  - target: test
    files:
      - tests/divSqrtTb.sv

//--- tests/divSqrtTb.sv
// Testbench for the half-precision divide and square-root unit
// Random and directed requests against an integer reference model,
// with concurrent assertions checking results, flags and timing

`timescale 1ns/100ps

module divSqrtTb;
  import divSqrtPkg::*;

  localparam int ClkPeriod = 8;
  localparam int NumDiv = 150;
  localparam int NumSqrt = 150;
  localparam int NumDirected = 12;
  // Rising edges from the start edge to the edge that raises done
  localparam int Latency = 8;
  // Roughly ten cycles per operation plus reset and idle gaps
  localparam int WatchCycles = (NumDiv + NumSqrt + NumDirected) * 10 + 100;

  logic clk;
  logic reset;
  logic start;
  divReqT req;
  logic busy;
  logic done;
  divResT res;

  // Expected result of the operation in flight
  divResT expRes;
  logic checkSticky;
  logic started;
  int issued;
  int doneCount;
  int cycle;
  int startEdge;
  int busyRun;
  int errors;
  int ops;

  divSqrtUnit UUT (.clk, .reset, .start, .req, .busy, .done, .res);

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // Edge counter, busy run length and completion bookkeeping
  always @(posedge clk) begin
    if (reset) begin
      cycle <= 0;
      busyRun <= 0;
      doneCount <= 0;
    end else begin
      cycle <= cycle + 1;
      busyRun <= busy ? busyRun + 1 : 0;
      if (done) begin
        doneCount <= doneCount + 1;
      end
    end
  end

  initial begin
    #(WatchCycles * ClkPeriod);
    $display("Timeout: run did not finish within %0d cycles", WatchCycles);
    $display("Some tests failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  // Normalize a U1.DivB mantissa, truncate and fold in the sticky bit
  function automatic divResT packResult(input logic [DivB:0] mant, input int e,
                                        input logic remNz, input logic zero,
                                        input logic divZero);
    logic [DivB:0] m;
    int ex;
    divResT o;
    m = mant;
    ex = e;
    if (!m[DivB]) begin
      m = m << 1;
      ex = ex - 1;
    end
    o.frac = m[DivB-1 -: Nf];
    o.sticky = remNz | (|m[DivB-Nf-1:0]);
    o.exp = Ne'(ex);
    o.zero = zero;
    o.divZero = divZero;
    // Special cases carry no magnitude
    if (zero || divZero) begin
      o.frac = '0;
      o.exp = '0;
    end
    return o;
  endfunction

  // floor(1.xFrac * 2^DivB / 1.yFrac) with its remainder
  function automatic divResT divideModel(input divReqT r);
    logic [2*DivB:0] num;
    logic [2*DivB:0] quo;
    logic [2*DivB:0] rem;
    int e;
    num = (2*DivB+1)'({1'b1, r.xFrac}) << DivB;
    quo = num / {1'b1, r.yFrac};
    rem = num % {1'b1, r.yFrac};
    e = int'(r.xExp) - int'(r.yExp) + Bias;
    return packResult(quo[DivB:0], e, rem != '0, r.xExp == '0, r.yExp == '0);
  endfunction

  // Bit-by-bit integer square root, one root bit per trial
  function automatic logic [DivB:0] bitSqrt(input logic [2*DivB+1:0] v);
    logic [DivB:0] root;
    logic [DivB:0] trial;
    int b;
    root = '0;
    for (b = DivB; b >= 0; b--) begin
      trial = root | ((DivB+1)'(1) << b);
      if ((2*DivB+2)'(trial) * (2*DivB+2)'(trial) <= v) begin
        root = trial;
      end
    end
    return root;
  endfunction

  function automatic divResT sqrtModel(input divReqT r);
    logic [DivB:0] ax;
    logic [2*DivB+1:0] rad;
    logic [DivB:0] root;
    int unb;
    int e;
    unb = int'(r.xExp) - Bias;
    // Odd exponent halves the radicand into [0.5, 1) and rounds the exponent up
    if ((unb & 1) != 0) begin
      ax = {2'b01, r.xFrac, 1'b0};
      e = (unb + 1) / 2 + Bias;
    end else begin
      ax = {1'b1, r.xFrac, 2'b00};
      e = unb / 2 + Bias;
    end
    rad = (2*DivB+2)'(ax) << DivB;
    root = bitSqrt(rad);
    return packResult(root, e, rad != root * root, r.xExp == '0, 1'b0);
  endfunction

  function automatic divReqT makeReq(input logic sqrt, input int xExp, input int xFrac,
                                     input int yExp, input int yFrac);
    divReqT r;
    r.sqrt = sqrt;
    r.xExp = Ne'(xExp);
    r.xFrac = Nf'(xFrac);
    r.yExp = Ne'(yExp);
    r.yFrac = Nf'(yFrac);
    return r;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  fracA: assert property (@(posedge clk) disable iff (reset)
    done |-> res.frac == expRes.frac)
    else begin
      errors++;
      $display("Mismatch res.frac: got 0x%h, expected 0x%h",
               $sampled(res.frac), $sampled(expRes.frac));
    end

  expA: assert property (@(posedge clk) disable iff (reset)
    done |-> res.exp == expRes.exp)
    else begin
      errors++;
      $display("Mismatch res.exp: got 0x%h, expected 0x%h",
               $sampled(res.exp), $sampled(expRes.exp));
    end

  // Sticky is meaningless once a special flag forces the result
  stickyA: assert property (@(posedge clk) disable iff (reset)
    done && checkSticky |-> res.sticky == expRes.sticky)
    else begin
      errors++;
      $display("Mismatch res.sticky: got 0x%h, expected 0x%h",
               $sampled(res.sticky), $sampled(expRes.sticky));
    end

  zeroA: assert property (@(posedge clk) disable iff (reset)
    done |-> res.zero == expRes.zero)
    else begin
      errors++;
      $display("Mismatch res.zero: got 0x%h, expected 0x%h",
               $sampled(res.zero), $sampled(expRes.zero));
    end

  divZeroA: assert property (@(posedge clk) disable iff (reset)
    done |-> res.divZero == expRes.divZero)
    else begin
      errors++;
      $display("Mismatch res.divZero: got 0x%h, expected 0x%h",
               $sampled(res.divZero), $sampled(expRes.divZero));
    end

  latencyA: assert property (@(posedge clk) disable iff (reset)
    $rose(done) |-> cycle == startEdge + Latency)
    else begin
      errors++;
      $display("done rose %0d edges after the start edge instead of %0d",
               $sampled(cycle) - $sampled(startEdge), Latency);
    end

  donePulseA: assert property (@(posedge clk) disable iff (reset)
    done |=> !done)
    else begin
      errors++;
      $display("done stayed high for more than one cycle");
    end

  busyLenA: assert property (@(posedge clk) disable iff (reset)
    $fell(busy) |-> busyRun == IterCycles)
    else begin
      errors++;
      $display("busy was high for %0d cycles instead of %0d", $sampled(busyRun), IterCycles);
    end

  // A start during an operation must never produce a second done
  orphanA: assert property (@(posedge clk) disable iff (reset)
    done |-> doneCount < issued)
    else begin
      errors++;
      $display("done arrived with no accepted request in flight");
    end

  idleA: assert property (@(posedge clk) disable iff (reset)
    !started |-> !busy && !done && res == '0)
    else begin
      errors++;
      $display("Outputs were not idle after reset before the first start");
    end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  // Called 1 ns after a rising edge, returns 1 ns after the start edge
  task automatic issue(input divReqT r);
    divResT e;
    e = r.sqrt ? sqrtModel(r) : divideModel(r);
    req = r;
    expRes = e;
    checkSticky = !(e.zero || e.divZero);
    issued++;
    started = 1'b1;
    startEdge = cycle + 1;
    start = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
  endtask

  task automatic waitDone();
    int n;
    logic seen;
    seen = 1'b0;
    for (n = 0; n < 20 && !seen; n++) begin
      @(negedge clk);
      seen = done;
    end
    if (!seen) begin
      errors++;
      $display("No done within 20 cycles of the start");
    end
    // Done is checked on this edge and the next drive follows 1 ns later
    @(posedge clk);
    #1;
  endtask

  task automatic runOp(input divReqT r);
    issue(r);
    waitDone();
    ops++;
  endtask

  task automatic reportTest(input string name, input int n, input int errBefore);
    $display("%s: %0d operations, %0d errors", name, n, errors - errBefore);
  endtask

  initial begin
    divReqT r;
    int errBefore;
    int i;
    void'($urandom(32'hd565_02ac));
    start = 1'b0;
    req = '0;
    reset = 1'b1;
    expRes = '0;
    checkSticky = 1'b0;
    started = 1'b0;
    issued = 0;
    startEdge = 0;
    errors = 0;
    ops = 0;
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;

    // Idle outputs before any request
    errBefore = errors;
    repeat (4) @(posedge clk);
    #1;
    reportTest("reset state", 0, errBefore);

    // Exponents kept clear of result wrap
    errBefore = errors;
    for (i = 0; i < NumDiv; i++) begin
      r = makeReq(1'b0, $urandom_range(22, 8), $urandom(), $urandom_range(22, 8), $urandom());
      runOp(r);
    end
    reportTest("random divide", NumDiv, errBefore);

    // Divisor fields are ignored for sqrt, so fill them with noise
    errBefore = errors;
    for (i = 0; i < NumSqrt; i++) begin
      r = makeReq(1'b1, $urandom_range(30, 1), $urandom(), $urandom(), $urandom());
      runOp(r);
    end
    reportTest("random sqrt", NumSqrt, errBefore);

    // Perfect squares of both exponent parities have sticky 0
    errBefore = errors;
    runOp(makeReq(1'b1, 15, 0, 0, 0));
    runOp(makeReq(1'b1, 15, 576, 0, 0));
    runOp(makeReq(1'b1, 16, 128, 0, 0));
    runOp(makeReq(1'b1, 17, 0, 0, 0));
    runOp(makeReq(1'b1, 13, 0, 0, 0));
    runOp(makeReq(1'b1, 14, 128, 0, 0));
    reportTest("perfect squares", 6, errBefore);

    // Second start held through load, busy and the last iteration cycle
    errBefore = errors;
    issue(makeReq(1'b0, 16, 300, 15, 700));
    req = makeReq(1'b0, 20, 5, 10, 900);
    start = 1'b1;
    repeat (8) @(posedge clk);
    #1;
    start = 1'b0;
    waitDone();
    ops++;
    repeat (12) @(posedge clk);
    #1;
    reportTest("start while busy", 1, errBefore);

    errBefore = errors;
    runOp(makeReq(1'b0, 0, 123, 15, 456));
    runOp(makeReq(1'b1, 0, 77, 0, 0));
    runOp(makeReq(1'b0, 18, 200, 0, 33));
    runOp(makeReq(1'b0, 0, 0, 0, 0));
    reportTest("zero operands", 4, errBefore);

    $display("Summary: %0d operations, %0d errors", ops, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- verilog/divSqrtUnit.sv
// Half-precision divide and square-root unit, top level
// Preprocessor, controller, two-digit iteration block, postprocessor

`timescale 1ns/100ps

module divSqrtUnit (
  input  logic               clk,
  input  logic               reset,
  input  logic               start,
  input  divSqrtPkg::divReqT req,
  output logic               busy,
  output logic               done,
  output divSqrtPkg::divResT res
);
  import divSqrtPkg::*;

  iterInitT init;
  logic accept;
  logic load;
  logic lastIter;
  logic [ResW-1:0] ws;
  logic [ResW-1:0] wc;
  logic [DivB:0] quot;
  logic [DivB:0] quotM;

  // Starts during an operation, its load or its last cycle are dropped
  assign accept = start & ~busy & ~load & ~lastIter;

  divSqrtPreproc uPreproc (
    .clk, .reset, .start(accept), .req, .init
  );

  // Completion is signalled by the result register
  divSqrtFsm uFsm (
    .clk, .reset, .start(accept), .busy, .load, .lastIter, .done()
  );

  divSqrtIter uIter (
    .clk, .load, .busy, .init, .ws, .wc, .quot, .quotM
  );

  divSqrtPostproc uPostproc (
    .clk, .reset, .lastIter, .ws, .wc, .quot, .quotM, .init, .done, .res
  );

endmodule

//--- verilog/divSqrtPostproc.sv
// Divide/sqrt postprocessor
// Resolves the remainder sign, picks quotient or quotient minus one,
// normalizes, and registers the result with sticky and flags

`timescale 1ns/100ps

module divSqrtPostproc (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        lastIter,
  input  logic [divSqrtPkg::ResW-1:0] ws,
  input  logic [divSqrtPkg::ResW-1:0] wc,
  input  logic [divSqrtPkg::DivB:0]   quot,
  input  logic [divSqrtPkg::DivB:0]   quotM,
  input  divSqrtPkg::iterInitT        init,
  output logic                        done,
  output divSqrtPkg::divResT          res
);
  import divSqrtPkg::*;

  logic [ResW-1:0] rem;
  logic [ResW-1:0] remFix;
  logic neg;
  logic [DivB:0] mant;
  logic lost;
  logic signed [Ne+1:0] expN;
  divResT nextRes;

  // Remainder after correcting the final digit down by one ulp
  assign rem = ws + wc;
  assign neg = rem[ResW-1];
  // Sqrt adds 4SM + 2^-(DivB-1), divide adds 2d
  assign remFix = init.sqrt ?
    rem + {1'b0, quotM, 2'b00} + {{(ResW-2){1'b0}}, 2'b10} :
    rem + {2'b00, 1'b1, init.d, {(DivB-Nf+1){1'b0}}};

  assign mant = neg ? quotM : quot;

  always_comb begin
    // Normalize on the integer bit
    if (mant[DivB]) begin
      nextRes.frac = mant[DivB-1 -: Nf];
      lost = |mant[DivB-Nf-1:0];
      expN = init.exp;
    end else begin
      nextRes.frac = mant[DivB-2 -: Nf];
      lost = |mant[DivB-Nf-2:0];
      expN = init.exp - 7'sd1;
    end
    nextRes.exp = expN[Ne-1:0];
    nextRes.sticky = lost | (neg ? |remFix : |rem);
    nextRes.zero = init.xZero;
    nextRes.divZero = init.divZero;
    // Special cases carry no magnitude
    if (init.xZero || init.divZero) begin
      nextRes.frac = '0;
      nextRes.exp = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      done <= 1'b0;
      res <= '0;
    end else begin
      done <= lastIter;
      if (lastIter) begin
        res <= nextRes;
      end
    end
  end

endmodule

//--- verilog/divSqrtFsm.sv
// Divide/sqrt controller
// Down counter over the iteration cycles, with load, busy,
// last-iteration and done strobes

`timescale 1ns/100ps

module divSqrtFsm (
  input  logic clk,
  input  logic reset,
  input  logic start,
  output logic busy,
  output logic load,
  output logic lastIter,
  output logic done
);
  import divSqrtPkg::*;

  logic [2:0] count;

  always_ff @(posedge clk) begin
    if (reset) begin
      load <= 1'b0;
      busy <= 1'b0;
      lastIter <= 1'b0;
      done <= 1'b0;
      count <= '0;
    end else begin
      // Accepted start becomes a load pulse
      load <= start & ~busy;
      lastIter <= busy && (count == '0);
      done <= lastIter;
      if (load) begin
        busy <= 1'b1;
        count <= 3'(IterCycles - 1);
      end else if (busy) begin
        if (count == '0) begin
          busy <= 1'b0;
        end else begin
          count <= count - 3'd1;
        end
      end
    end
  end

  doneLoadA: assert property (@(posedge clk) disable iff (reset)
    !(done && load));

  // Busy drops right after the iteration cycles
  busyLenA: assert property (@(posedge clk) disable iff (reset)
    $rose(busy) |-> ##IterCycles !busy);

endmodule

//--- verilog/divSqrtIter.sv
// Divide/sqrt iteration block
// Holds the carry-save remainder, divisor, root position constant
// and quotient/root pairs, and advances two digits per clock

`timescale 1ns/100ps

module divSqrtIter (
  input  logic                        clk,
  input  logic                        load,
  input  logic                        busy,
  input  divSqrtPkg::iterInitT        init,
  output logic [divSqrtPkg::ResW-1:0] ws,
  output logic [divSqrtPkg::ResW-1:0] wc,
  output logic [divSqrtPkg::DivB:0]   quot,
  output logic [divSqrtPkg::DivB:0]   quotM
);
  import divSqrtPkg::*;

  logic [Nf-1:0] dReg;
  logic [DivB-1:0] cReg;
  logic [DivB:0] qReg;
  logic [DivB:0] qmReg;
  logic [DivB:0] sReg;
  logic [DivB:0] smReg;
  logic signed [3:0] estTop;

  // Chain nodes, index 0 is the register side
  logic [ResW-1:0] wsA [DivCopies+1];
  logic [ResW-1:0] wcA [DivCopies+1];
  logic [DivB:0] qA [DivCopies+1];
  logic [DivB:0] qmA [DivCopies+1];
  logic [DivB:0] sA [DivCopies+1];
  logic [DivB:0] smA [DivCopies+1];
  logic [DivB-1:0] cA [DivCopies+1];

  assign wsA[0] = ws;
  assign wcA[0] = wc;
  assign qA[0] = qReg;
  assign qmA[0] = qmReg;
  assign sA[0] = sReg;
  assign smA[0] = smReg;
  assign cA[0] = cReg;

  for (genvar i = 0; i < DivCopies; i++) begin : gStage
    divSqrtStage uStage (
      .ws(wsA[i]), .wc(wcA[i]), .d(dReg), .sqrt(init.sqrt),
      .q(qA[i]), .qm(qmA[i]), .s(sA[i]), .sm(smA[i]), .c(cA[i]),
      .wsNext(wsA[i+1]), .wcNext(wcA[i+1]),
      .qNext(qA[i+1]), .qmNext(qmA[i+1]),
      .sNext(sA[i+1]), .smNext(smA[i+1]), .cNext(cA[i+1])
    );
  end

  ////////////////////////////////////////////////////////////////////////////
  // Registers with start muxes
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (load) begin
      // Sqrt starts from 2(x - 1) with root 1, divide from x
      if (init.sqrt) begin
        ws <= {2'b00, init.x, 1'b0} - {4'b0010, {DivB{1'b0}}};
      end else begin
        ws <= {3'b000, init.x};
      end
      wc <= '0;
      dReg <= init.d;
      // First root digit has weight 1/2
      cReg <= {1'b1, {(DivB-1){1'b0}}};
      qReg <= '0;
      qmReg <= '1;
      sReg <= {1'b1, {DivB{1'b0}}};
      smReg <= '0;
    end else if (busy) begin
      ws <= wsA[DivCopies];
      wc <= wcA[DivCopies];
      cReg <= cA[DivCopies];
      qReg <= qA[DivCopies];
      qmReg <= qmA[DivCopies];
      sReg <= sA[DivCopies];
      smReg <= smA[DivCopies];
    end
  end

  // Divide digits sit one place low, realign to U1.DivB
  assign quot = init.sqrt ? sReg : {qReg[DivB-1:0], 1'b0};
  assign quotM = init.sqrt ? smReg : {qmReg[DivB-1:0], 1'b0};

  // Estimate must stay clear of the Q4 wrap for the whole iteration
  assign estTop = ws[ResW-1:ResW-4] + wc[ResW-1:ResW-4];

  estRangeA: assert property (@(posedge clk)
    busy |-> (estTop >= -4'sd6) && (estTop <= 4'sd5));

endmodule

//--- verilog/divSqrtStage.sv
// One radix-2 SRT step for divide or square root
// Digit selection from the remainder estimate, carry-save update
// and on-the-fly conversion of quotient and root

`timescale 1ns/100ps

module divSqrtStage (
  input  logic [divSqrtPkg::ResW-1:0] ws,
  input  logic [divSqrtPkg::ResW-1:0] wc,
  input  logic [divSqrtPkg::Nf-1:0]   d,
  input  logic                        sqrt,
  input  logic [divSqrtPkg::DivB:0]   q,
  input  logic [divSqrtPkg::DivB:0]   qm,
  input  logic [divSqrtPkg::DivB:0]   s,
  input  logic [divSqrtPkg::DivB:0]   sm,
  input  logic [divSqrtPkg::DivB-1:0] c,
  output logic [divSqrtPkg::ResW-1:0] wsNext,
  output logic [divSqrtPkg::ResW-1:0] wcNext,
  output logic [divSqrtPkg::DivB:0]   qNext,
  output logic [divSqrtPkg::DivB:0]   qmNext,
  output logic [divSqrtPkg::DivB:0]   sNext,
  output logic [divSqrtPkg::DivB:0]   smNext,
  output logic [divSqrtPkg::DivB-1:0] cNext
);
  import divSqrtPkg::*;

  logic signed [3:0] est;
  logic qPos;
  logic qNeg;
  logic [DivB:0] cWide;
  logic [DivB:0] c3;
  logic [ResW-1:0] dTerm;
  logic [ResW-1:0] posTerm;
  logic [ResW-1:0] negTerm;
  logic [ResW-1:0] addend;
  logic [ResW-1:0] csaSum;
  logic [ResW-1:0] csaMaj;
  logic [ResW-1:0] csaCarry;

  // Integer part of the shifted remainder, off by less than 2
  assign est = ws[ResW-1:ResW-4] + wc[ResW-1:ResW-4];
  // est >= 0 gives +1, est == -1 gives 0, below that -1
  assign qPos = ~est[3];
  assign qNeg = est[3] & (est != -4'sd1);

  ////////////////////////////////////////////////////////////////////////////
  // Subtrahend selection
  ////////////////////////////////////////////////////////////////////////////

  // c is one-hot at weight 2^-(j+1)
  assign cWide = {1'b0, c};
  assign c3 = {c, 1'b0} | cWide;
  // Divisor 1.d in Q4.DivB
  assign dTerm = {3'b000, 1'b1, d, {(DivB-Nf){1'b0}}};
  // Sqrt, +1 digit: 2S + 2^-(j+1)
  assign posTerm = sqrt ? ({2'b00, s, 1'b0} | {3'b000, cWide}) : dTerm;
  // Sqrt, -1 digit: 2S - 2^-(j+1) = 2SM + 3*2^-(j+1)
  assign negTerm = sqrt ? ({2'b00, sm, 1'b0} | {3'b000, c3}) : dTerm;

  // Subtract via inverted term plus a carry-in in the free carry LSB
  assign addend = qPos ? ~posTerm : (qNeg ? negTerm : '0);

  // 3:2 carry-save adder
  assign csaSum = ws ^ wc ^ addend;
  assign csaMaj = (ws & wc) | (ws & addend) | (wc & addend);
  assign csaCarry = {csaMaj[ResW-2:0], qPos};

  // Next remainder is already doubled
  assign wsNext = {csaSum[ResW-2:0], 1'b0};
  assign wcNext = {csaCarry[ResW-2:0], 1'b0};

  ////////////////////////////////////////////////////////////////////////////
  // On-the-fly conversion
  ////////////////////////////////////////////////////////////////////////////

  // Quotient digits shift in at the LSB
  always_comb begin
    if (qPos) begin
      qNext = {q[DivB-1:0], 1'b1};
      qmNext = {q[DivB-1:0], 1'b0};
    end else if (qNeg) begin
      qNext = {qm[DivB-1:0], 1'b1};
      qmNext = {qm[DivB-1:0], 1'b0};
    end else begin
      qNext = {q[DivB-1:0], 1'b0};
      qmNext = {qm[DivB-1:0], 1'b1};
    end
  end

  // Root digits land at the position marked by c
  always_comb begin
    if (qPos) begin
      sNext = s | cWide;
      smNext = s;
    end else if (qNeg) begin
      sNext = sm | cWide;
      smNext = sm;
    end else begin
      sNext = s;
      smNext = sm | cWide;
    end
  end

  assign cNext = {1'b0, c[DivB-1:1]};

endmodule

//--- verilog/divSqrtPreproc.sv
// Divide/sqrt preprocessor
// Captures an accepted request, aligns the radicand for odd exponents
// and forms the provisional result exponent and the zero flags

`timescale 1ns/100ps

module divSqrtPreproc (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 start,
  input  divSqrtPkg::divReqT   req,
  output divSqrtPkg::iterInitT init
);
  import divSqrtPkg::*;

  iterInitT nextInit;
  logic signed [Ne+1:0] biasS;
  logic signed [Ne+1:0] xExpS;
  logic signed [Ne+1:0] yExpS;
  // Unbiased dividend or radicand exponent
  logic signed [Ne+1:0] unb;
  logic signed [Ne+1:0] expDiv;
  logic signed [Ne+1:0] expSqrt;

  always_comb begin
    biasS = $signed((Ne+2)'(Bias));
    xExpS = $signed({2'b00, req.xExp});
    yExpS = $signed({2'b00, req.yExp});
    unb = xExpS - biasS;
    expDiv = xExpS - yExpS + biasS;
    // Halve, rounded up when odd since the radicand gets halved too
    expSqrt = ((unb + 1) >>> 1) + biasS;

    nextInit.sqrt = req.sqrt;
    nextInit.d = req.yFrac;
    // Odd exponent: 0.1xFrac, radicand lands in [0.5, 1)
    if (req.sqrt && unb[0]) begin
      nextInit.x = {2'b01, req.xFrac, 1'b0};
    end else begin
      nextInit.x = {1'b1, req.xFrac, 2'b00};
    end
    nextInit.exp = req.sqrt ? expSqrt : expDiv;
    nextInit.xZero = (req.xExp == '0);
    // No divisor for sqrt
    nextInit.divZero = ~req.sqrt & (req.yExp == '0);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      init <= '0;
    end else if (start) begin
      init <= nextInit;
    end
  end

endmodule

//--- verilog/divSqrtPkg.sv
// Divide and square-root unit, shared definitions
// Half-precision operand sizes, iteration sizes and the structs
// that carry a request, the preprocessed operands and a result

package divSqrtPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Operand format
  ////////////////////////////////////////////////////////////////////////////

  // Biased exponent width
  localparam int Ne = 5;
  // Fraction width, leading one implied
  localparam int Nf = 10;
  localparam int Bias = 15;

  ////////////////////////////////////////////////////////////////////////////
  // Iteration sizing
  ////////////////////////////////////////////////////////////////////////////

  // Digits produced over the whole operation, quotient is U1.DivB
  localparam int DivB = 12;
  // Stage copies chained per clock
  localparam int DivCopies = 2;
  localparam int IterCycles = DivB / DivCopies;
  // Carry-save remainder, Q4.DivB
  localparam int ResW = DivB + 4;

  // One operation as seen at the top level
  typedef struct packed {
    logic sqrt;
    logic [Ne-1:0] xExp;
    logic [Nf-1:0] xFrac;
    logic [Ne-1:0] yExp;
    logic [Nf-1:0] yFrac;
  } divReqT;

  // One result
  typedef struct packed {
    logic [Ne-1:0] exp;
    logic [Nf-1:0] frac;
    logic sticky;
    logic zero;
    logic divZero;
  } divResT;

  // Registered preprocessor output, held for the whole operation
  typedef struct packed {
    logic [DivB:0] x;
    logic [Nf-1:0] d;
    logic sqrt;
    // Signed, room for under- and overflow
    logic signed [Ne+1:0] exp;
    logic xZero;
    logic divZero;
  } iterInitT;

endpackage
